// File: Makefile
# tool, flags, top module and file list
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_nes_shell
FILELIST  = nes_shell.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the simulator exit status
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "result: pass"; \
	else \
	  echo "result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: nes_shell.f
rtl/shell_pkg.sv
rtl/bridge_decode.sv
rtl/host_regs.sv
rtl/video_out.sv
rtl/nes_shell.sv
tests/shell_checker.sv
tests/tb_nes_shell.sv

// File: rtl/bridge_decode.sv
/*
 * host bridge decode
 * full address match of settings writes into one-hot enables,
 * read data selection by command page and save regions
 */
`timescale 1ns/10ps

module bridge_decode (
  input  logic                             clk_74a,
  input  logic                             pll_core_locked,
  input  shell_pkg::bridge_addr_t          bridge_addr,
  input  logic                             bridge_wr,
  input  logic                             bridge_rd,
  input  logic [shell_pkg::DATA_WIDTH-1:0] cmd_rd_data,
  input  logic [shell_pkg::DATA_WIDTH-1:0] save_rd_data,
  input  logic [shell_pkg::DATA_WIDTH-1:0] savestate_rd_data,
  output shell_pkg::reg_sel_t              reg_sel,
  output logic [shell_pkg::DATA_WIDTH-1:0] bridge_rd_data
);

  ////////////////////////////////////////
  // write decode

  // address matches, one per setting
  logic hit_overscan;
  logic hit_edges;
  logic hit_sprites;
  logic hit_palette;
  logic hit_multitap;

  // whole 32-bit word compared, no partial decode
  assign hit_overscan = (bridge_addr == shell_pkg::REG_HIDE_OVERSCAN);
  assign hit_edges    = (bridge_addr == shell_pkg::REG_MASK_EDGES);
  assign hit_sprites  = (bridge_addr == shell_pkg::REG_EXTRA_SPRITES);
  assign hit_palette  = (bridge_addr == shell_pkg::REG_PALETTE);
  assign hit_multitap = (bridge_addr == shell_pkg::REG_MULTITAP);

  // enables only while the write strobe is up
  always_comb begin
    reg_sel = '0;
    if (bridge_wr) begin
      reg_sel.hide_overscan = hit_overscan;
      reg_sel.mask_edges    = hit_edges;
      reg_sel.extra_sprites = hit_sprites;
      reg_sel.palette       = hit_palette;
      reg_sel.multitap      = hit_multitap;
    end
  end

  ////////////////////////////////////////
  // read select

  // read data is a pure decode of the address, the rd strobe is
  // not needed to qualify it
  // page F8 has region nibble F, so no overlap with the save regions
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr.pg.page == shell_pkg::PAGE_CMD) begin
      // command handler page
      bridge_rd_data = cmd_rd_data;
    end else if (bridge_addr.rgn.region == shell_pkg::REGION_SAVE) begin
      // save ram readback
      bridge_rd_data = save_rd_data;
    end else if (bridge_addr.rgn.region == shell_pkg::REGION_SAVESTATE) begin
      // save state readback
      bridge_rd_data = savestate_rd_data;
    end
  end

endmodule

// File: rtl/host_regs.sv
/*
 * host settings registers
 * overscan, edge mask, extra sprites, palette and multitap,
 * plus the save-ram size entry published to the data table
 */
`timescale 1ns/10ps

module host_regs #(
  parameter logic [shell_pkg::DATA_WIDTH-1:0] SAVE_SIZE_BYTES = 32'h0004_0000
) (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,
  input  shell_pkg::reg_sel_t                 reg_sel,
  input  logic [shell_pkg::DATA_WIDTH-1:0]    bridge_wr_data,
  input  logic                                has_save,
  output logic                                hide_overscan,
  output logic [shell_pkg::MASK_WIDTH-1:0]    mask_vid_edges,
  output logic                                allow_extra_sprites,
  output logic [shell_pkg::PALETTE_WIDTH-1:0] selected_palette,
  output logic                                multitap_enabled,
  output logic [shell_pkg::DT_ADDR_WIDTH-1:0] datatable_addr,
  output logic                                datatable_wren,
  output logic [shell_pkg::DATA_WIDTH-1:0]    datatable_data
);

  ////////////////////////////////////////
  // emulator settings

  // each field takes the low bits of the bus word
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
    end else begin
      if (reg_sel.hide_overscan) begin
        hide_overscan <= bridge_wr_data[0];
      end
      // left and right edge masking
      if (reg_sel.mask_edges) begin
        mask_vid_edges <= bridge_wr_data[shell_pkg::MASK_WIDTH-1:0];
      end
      if (reg_sel.extra_sprites) begin
        allow_extra_sprites <= bridge_wr_data[0];
      end
      // palette index
      if (reg_sel.palette) begin
        selected_palette <= bridge_wr_data[shell_pkg::PALETTE_WIDTH-1:0];
      end
      if (reg_sel.multitap) begin
        multitap_enabled <= bridge_wr_data[0];
      end
    end
  end

  ////////////////////////////////////////
  // data table save size

  // rewritten every cycle, so has_save changes land one edge later
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      // slot index 1, size word
      datatable_addr <= shell_pkg::DT_SAVE_ENTRY;
      datatable_data <= has_save ? SAVE_SIZE_BYTES : '0;
    end
  end

endmodule

// File: rtl/nes_shell.sv
/*
 * shell top level
 * bridge decode, settings registers and video conditioning on clk_74a
 */
`timescale 1ns/10ps

module nes_shell #(
  parameter int HS_DELAY = 7,
  parameter logic [shell_pkg::DATA_WIDTH-1:0] SAVE_SIZE_BYTES = 32'h0004_0000
) (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,

  // host bridge
  input  logic [shell_pkg::ADDR_WIDTH-1:0]    bridge_addr,
  input  logic                                bridge_wr,
  input  logic [shell_pkg::DATA_WIDTH-1:0]    bridge_wr_data,
  input  logic                                bridge_rd,
  output logic [shell_pkg::DATA_WIDTH-1:0]    bridge_rd_data,

  // external read sources
  input  logic [shell_pkg::DATA_WIDTH-1:0]    cmd_rd_data,
  input  logic [shell_pkg::DATA_WIDTH-1:0]    save_rd_data,
  input  logic [shell_pkg::DATA_WIDTH-1:0]    savestate_rd_data,

  // emulator side
  input  logic                                has_save,
  input  logic                                h_blank,
  input  logic                                v_blank,
  input  logic                                hs_in,
  input  logic                                vs_in,
  input  logic [shell_pkg::RGB_WIDTH-1:0]     rgb_in,

  // settings to the emulator
  output logic                                hide_overscan,
  output logic [shell_pkg::MASK_WIDTH-1:0]    mask_vid_edges,
  output logic                                allow_extra_sprites,
  output logic [shell_pkg::PALETTE_WIDTH-1:0] selected_palette,
  output logic                                multitap_enabled,

  // host data table
  output logic [shell_pkg::DT_ADDR_WIDTH-1:0] datatable_addr,
  output logic                                datatable_wren,
  output logic [shell_pkg::DATA_WIDTH-1:0]    datatable_data,

  // scaler video
  output logic                                video_de,
  output logic                                video_hs,
  output logic                                video_vs,
  output logic [shell_pkg::RGB_WIDTH-1:0]     video_rgb
);

  // write enables, decode to registers
  shell_pkg::reg_sel_t reg_sel;

  ////////////////////////////////////////
  // bridge decode

  bridge_decode bridge_decode_i (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .bridge_addr       (shell_pkg::bridge_addr_t'(bridge_addr)),
    .bridge_wr         (bridge_wr),
    .bridge_rd         (bridge_rd),
    .cmd_rd_data       (cmd_rd_data),
    .save_rd_data      (save_rd_data),
    .savestate_rd_data (savestate_rd_data),
    .reg_sel           (reg_sel),
    .bridge_rd_data    (bridge_rd_data)
  );

  // settings and data table
  host_regs #(
    .SAVE_SIZE_BYTES (SAVE_SIZE_BYTES)
  ) host_regs_i (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .reg_sel             (reg_sel),
    .bridge_wr_data      (bridge_wr_data),
    .has_save            (has_save),
    .hide_overscan       (hide_overscan),
    .mask_vid_edges      (mask_vid_edges),
    .allow_extra_sprites (allow_extra_sprites),
    .selected_palette    (selected_palette),
    .multitap_enabled    (multitap_enabled),
    .datatable_addr      (datatable_addr),
    .datatable_wren      (datatable_wren),
    .datatable_data      (datatable_data)
  );

  ////////////////////////////////////////
  // video result

  // overscan setting also feeds the slot word
  video_out #(
    .HS_DELAY (HS_DELAY)
  ) video_out_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .hs_in           (hs_in),
    .vs_in           (vs_in),
    .rgb_in          (rgb_in),
    .hide_overscan   (hide_overscan),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

// File: rtl/shell_pkg.sv
/*
 * shared definitions for the shell
 * bus widths, settings register addresses, bridge region and page codes,
 * the two views of the bridge address and the register write-enable bundle
 */
package shell_pkg;

  ////////////////////////////////////////
  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // settings register write addresses
  localparam logic [ADDR_WIDTH-1:0] REG_HIDE_OVERSCAN = 32'h0000_0200;
  localparam logic [ADDR_WIDTH-1:0] REG_MASK_EDGES    = 32'h0000_0204;
  localparam logic [ADDR_WIDTH-1:0] REG_EXTRA_SPRITES = 32'h0000_0208;
  localparam logic [ADDR_WIDTH-1:0] REG_PALETTE       = 32'h0000_020C;
  localparam logic [ADDR_WIDTH-1:0] REG_MULTITAP      = 32'h0000_0300;

  // top nibble regions and top byte pages
  localparam logic [3:0] REGION_SAVE      = 4'h2;
  localparam logic [3:0] REGION_SAVESTATE = 4'h4;
  localparam logic [7:0] PAGE_CMD         = 8'hF8;

  ////////////////////////////////////////
  // setting and video widths
  localparam int MASK_WIDTH        = 2;
  localparam int PALETTE_WIDTH     = 3;
  localparam int RGB_WIDTH         = 24;
  // hide overscan flag position in the slot word
  localparam int SLOT_OVERSCAN_BIT = 13;

  // host data table, slot index 1 size word
  localparam int DT_ADDR_WIDTH = 10;
  localparam logic [DT_ADDR_WIDTH-1:0] DT_SAVE_ENTRY = 10'd3;

  ////////////////////////////////////////
  // save and save-state regions
  typedef struct packed {
    logic [3:0]            region;
    logic [ADDR_WIDTH-5:0] offset;
  } region_view_t;

  // command page
  typedef struct packed {
    logic [7:0]            page;
    logic [ADDR_WIDTH-9:0] offset;
  } page_view_t;

  typedef union packed {
    region_view_t rgn;
    page_view_t   pg;
  } bridge_addr_t;

  // one write enable per setting
  typedef struct packed {
    logic hide_overscan;
    logic mask_edges;
    logic extra_sprites;
    logic palette;
    logic multitap;
  } reg_sel_t;

endpackage

// File: rtl/video_out.sv
/*
 * scaler video conditioning
 * registered data enable and colour, slot word after each active line,
 * delayed one-cycle hsync and one-cycle vsync
 */
`timescale 1ns/10ps

module video_out #(
  parameter int HS_DELAY = 7
) (
  input  logic                            clk_74a,
  input  logic                            pll_core_locked,
  input  logic                            h_blank,
  input  logic                            v_blank,
  input  logic                            hs_in,
  input  logic                            vs_in,
  input  logic [shell_pkg::RGB_WIDTH-1:0] rgb_in,
  input  logic                            hide_overscan,
  output logic                            video_de,
  output logic                            video_hs,
  output logic                            video_vs,
  output logic [shell_pkg::RGB_WIDTH-1:0] video_rgb
);

  // countdown wide enough to hold HS_DELAY
  localparam int CNT_W = $clog2(HS_DELAY + 1);
  localparam logic [CNT_W-1:0] HS_LOAD = CNT_W'(HS_DELAY);

  // raw active area
  logic de;
  // previous-cycle copies for edge detect
  logic de_prev;
  logic hs_prev;
  logic vs_prev;
  logic de_fall;
  logic hs_rise;
  logic vs_rise;
  // cycles left until the hsync pulse
  logic [CNT_W-1:0] hs_count;
  logic [shell_pkg::RGB_WIDTH-1:0] slot_word;

  assign de      = ~(h_blank | v_blank);
  assign de_fall = de_prev & ~de;
  assign hs_rise = hs_in & ~hs_prev;
  assign vs_rise = vs_in & ~vs_prev;

  // slot word, only the overscan flag is set
  always_comb begin
    slot_word = '0;
    slot_word[shell_pkg::SLOT_OVERSCAN_BIT] = hide_overscan;
  end

  ////////////////////////////////////////
  // enable and colour

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
      de_prev   <= 1'b0;
    end else begin
      video_de <= de;
      de_prev  <= de;
      if (de) begin
        video_rgb <= rgb_in;
      end else if (de_fall) begin
        // first blank cycle carries the slot word
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

  ////////////////////////////////////////
  // sync shaping

  // hsync pushed HS_DELAY edges out so it never sits on vsync
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_count <= '0;
      hs_prev  <= 1'b0;
      video_hs <= 1'b0;
    end else begin
      hs_prev  <= hs_in;
      // pulse when the count runs out
      video_hs <= (hs_count == CNT_W'(1));
      if (hs_rise) begin
        // retrigger restarts from the top
        hs_count <= HS_LOAD;
      end else if (hs_count != '0) begin
        hs_count <= hs_count - CNT_W'(1);
      end
    end
  end

  // vsync cut to a single cycle on its rising edge
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs_prev  <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      vs_prev  <= vs_in;
      video_vs <= vs_rise;
    end
  end

endmodule

// File: tests/shell_checker.sv
/*
 * output checker for the shell
 * reference model of settings, read select, data table and video,
 * compared with the DUT on every rising edge
 */
`timescale 1ns/10ps

module shell_checker #(
  parameter int          HS_DELAY        = 7,
  parameter logic [31:0] SAVE_SIZE_BYTES = 32'h0004_0000
) (
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  logic [31:0] bridge_addr,
  input  logic        bridge_wr,
  input  logic [31:0] bridge_wr_data,
  input  logic [31:0] bridge_rd_data,
  input  logic [31:0] cmd_rd_data,
  input  logic [31:0] save_rd_data,
  input  logic [31:0] savestate_rd_data,
  input  logic        has_save,
  input  logic        h_blank,
  input  logic        v_blank,
  input  logic        hs_in,
  input  logic        vs_in,
  input  logic [23:0] rgb_in,
  input  logic        hide_overscan,
  input  logic [1:0]  mask_vid_edges,
  input  logic        allow_extra_sprites,
  input  logic [2:0]  selected_palette,
  input  logic        multitap_enabled,
  input  logic [9:0]  datatable_addr,
  input  logic        datatable_wren,
  input  logic [31:0] datatable_data,
  input  logic        video_de,
  input  logic        video_hs,
  input  logic        video_vs,
  input  logic [23:0] video_rgb,
  output int          error_count,
  output int          check_count
);

  int errors = 0;
  int checks = 0;
  // expected registered outputs, valid after the last edge
  logic        exp_overscan;
  logic [1:0]  exp_mask;
  logic        exp_sprites;
  logic [2:0]  exp_palette;
  logic        exp_multitap;
  logic [9:0]  exp_dt_addr;
  logic        exp_dt_wren;
  logic [31:0] exp_dt_data;
  logic        exp_de;
  logic        exp_hs;
  logic        exp_vs;
  logic [23:0] exp_rgb;
  // history of the video inputs
  logic        active;
  logic        was_active;
  logic        was_hs;
  logic        was_vs;
  // edge number of the last hsync rise
  logic        hs_armed;
  int          hs_rise_edge;
  int          edge_num;
  logic        model_valid = 1'b0;

  assign error_count = errors;
  assign check_count = checks;

  ////////////////////////////////////////
  // reference functions

  // page F8 first, then save and save-state regions
  function automatic logic [31:0] expected_rd_data(input logic [31:0] addr,
      input logic [31:0] cmd, input logic [31:0] save, input logic [31:0] state);
    if (addr[31:24] == 8'hF8) return cmd;
    if (addr[31:28] == 4'h2) return save;
    if (addr[31:28] == 4'h4) return state;
    return 32'd0;
  endfunction

  // colour while active, slot word on the first blank cycle
  function automatic logic [23:0] expected_rgb(input logic now_active,
      input logic prev_active, input logic [23:0] rgb, input logic overscan);
    logic [23:0] slot;
    slot = 24'd0;
    slot[13] = overscan;
    if (now_active) return rgb;
    if (prev_active) return slot;
    return 24'd0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
    end
  endtask

  ////////////////////////////////////////
  // model update

  task automatic reset_model();
    exp_overscan = 1'b0;
    exp_mask     = 2'd0;
    exp_sprites  = 1'b0;
    exp_palette  = 3'd0;
    exp_multitap = 1'b0;
    exp_dt_addr  = 10'd0;
    exp_dt_wren  = 1'b0;
    exp_dt_data  = 32'd0;
    exp_de       = 1'b0;
    exp_hs       = 1'b0;
    exp_vs       = 1'b0;
    exp_rgb      = 24'd0;
    was_active   = 1'b0;
    was_hs       = 1'b0;
    was_vs       = 1'b0;
    hs_armed     = 1'b0;
    edge_num     = 0;
  endtask

  task automatic step_model();
    active = !(h_blank || v_blank);
    // slot word sees overscan from before this edge
    exp_rgb = expected_rgb(active, was_active, rgb_in, exp_overscan);
    exp_de  = active;
    // pulse exactly HS_DELAY edges after the latest rise
    exp_hs  = hs_armed && (edge_num - hs_rise_edge == HS_DELAY);
    if (hs_in && !was_hs) begin
      hs_armed     = 1'b1;
      hs_rise_edge = edge_num;
    end
    exp_vs     = vs_in && !was_vs;
    was_active = active;
    was_hs     = hs_in;
    was_vs     = vs_in;
    if (bridge_wr) begin
      case (bridge_addr)
        32'h0000_0200: exp_overscan = bridge_wr_data[0];
        32'h0000_0204: exp_mask = bridge_wr_data[1:0];
        32'h0000_0208: exp_sprites = bridge_wr_data[0];
        32'h0000_020C: exp_palette = bridge_wr_data[2:0];
        32'h0000_0300: exp_multitap = bridge_wr_data[0];
        default: ;
      endcase
    end
    // save size entry, slot index 1
    exp_dt_wren = 1'b1;
    exp_dt_addr = 10'd3;
    exp_dt_data = has_save ? SAVE_SIZE_BYTES : 32'd0;
    edge_num++;
  endtask

  task automatic compare_outputs();
    check_value("hide_overscan", 32'(hide_overscan), 32'(exp_overscan));
    check_value("mask_vid_edges", 32'(mask_vid_edges), 32'(exp_mask));
    check_value("allow_extra_sprites", 32'(allow_extra_sprites), 32'(exp_sprites));
    check_value("selected_palette", 32'(selected_palette), 32'(exp_palette));
    check_value("multitap_enabled", 32'(multitap_enabled), 32'(exp_multitap));
    check_value("datatable_addr", 32'(datatable_addr), 32'(exp_dt_addr));
    check_value("datatable_wren", 32'(datatable_wren), 32'(exp_dt_wren));
    check_value("datatable_data", datatable_data, exp_dt_data);
    check_value("video_de", 32'(video_de), 32'(exp_de));
    check_value("video_hs", 32'(video_hs), 32'(exp_hs));
    check_value("video_vs", 32'(video_vs), 32'(exp_vs));
    check_value("video_rgb", 32'(video_rgb), 32'(exp_rgb));
  endtask

  ////////////////////////////////////////
  // compare on every rising edge, before the DUT registers update
  always @(posedge clk_74a) begin
    // read path is combinational, checked in the address cycle
    check_value("bridge_rd_data", bridge_rd_data,
                expected_rd_data(bridge_addr, cmd_rd_data, save_rd_data, savestate_rd_data));
    if (!pll_core_locked) begin
      reset_model();
      model_valid = 1'b1;
    end else if (model_valid) begin
      compare_outputs();
      step_model();
    end
  end

endmodule

// File: tests/tb_nes_shell.sv
/*
 * testbench for the shell
 * clock, reset, random bridge and video stimulus, timeout and closing report
 */
`timescale 1ns/10ps

module tb_nes_shell;

  localparam int          HS_DELAY        = 7;
  localparam logic [31:0] SAVE_SIZE_BYTES = 32'h0004_0000;
  localparam logic [31:0] SEED            = 32'h447beaae;
  localparam int          RESET_CYCLES    = 2;
  localparam int          WRITE_CYCLES    = 500;
  localparam int          READ_CYCLES     = 400;
  localparam int          VIDEO_CYCLES    = 800;
  localparam int          MIXED_CYCLES    = 300;
  // two resets and a short tail
  localparam int TEST_CYCLES = 2 * RESET_CYCLES + WRITE_CYCLES + READ_CYCLES
                               + VIDEO_CYCLES + MIXED_CYCLES + 4;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic        clk_74a;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic        bridge_rd;
  logic [31:0] bridge_rd_data;
  logic [31:0] cmd_rd_data;
  logic [31:0] save_rd_data;
  logic [31:0] savestate_rd_data;
  logic        has_save;
  logic        h_blank;
  logic        v_blank;
  logic        hs_in;
  logic        vs_in;
  logic [23:0] rgb_in;
  logic        hide_overscan;
  logic [1:0]  mask_vid_edges;
  logic        allow_extra_sprites;
  logic [2:0]  selected_palette;
  logic        multitap_enabled;
  logic [9:0]  datatable_addr;
  logic        datatable_wren;
  logic [31:0] datatable_data;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic [23:0] video_rgb;
  int          error_count;
  int          check_count;
  int          cycle_count = 0;

  nes_shell #(
    .HS_DELAY        (HS_DELAY),
    .SAVE_SIZE_BYTES (SAVE_SIZE_BYTES)
  ) nes_shell_i (.*);

  shell_checker #(
    .HS_DELAY        (HS_DELAY),
    .SAVE_SIZE_BYTES (SAVE_SIZE_BYTES)
  ) shell_checker_i (.*);

  ////////////////////////////////////////
  // clock, 8 ns period
  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  // one of the five settings addresses
  function automatic logic [31:0] reg_address(input int idx);
    case (idx)
      0: return 32'h0000_0200;
      1: return 32'h0000_0204;
      2: return 32'h0000_0208;
      3: return 32'h0000_020C;
      default: return 32'h0000_0300;
    endcase
  endfunction

  task automatic hold_reset();
    pll_core_locked = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_74a);
    pll_core_locked = 1'b1;
  endtask

  // read sources and has_save change freely
  task automatic drive_sources();
    cmd_rd_data       = $urandom;
    save_rd_data      = $urandom;
    savestate_rd_data = $urandom;
    if (($urandom % 8) == 0) has_save = ~has_save;
  endtask

  // exact hits, one-bit misses and random addresses
  task automatic drive_write();
    case (int'($urandom % 3))
      0: bridge_addr = reg_address(int'($urandom % 5));
      1: bridge_addr = reg_address(int'($urandom % 5)) ^ (32'd1 << ($urandom % 32));
      default: bridge_addr = $urandom;
    endcase
    bridge_wr      = ($urandom % 4) != 0;
    bridge_wr_data = $urandom;
    bridge_rd      = 1'b0;
  endtask

  // command page, save, save state, anything
  task automatic drive_read();
    case (int'($urandom % 4))
      0: bridge_addr = {8'hF8, 24'($urandom)};
      1: bridge_addr = {4'h2, 28'($urandom)};
      2: bridge_addr = {4'h4, 28'($urandom)};
      default: bridge_addr = $urandom;
    endcase
    bridge_wr = 1'b0;
    bridge_rd = 1'b1;
  endtask

  // toggle rates give runs of blank and varied hsync spacing
  task automatic drive_video();
    if (($urandom % 6) == 0) h_blank = ~h_blank;
    if (($urandom % 50) == 0) v_blank = ~v_blank;
    if (($urandom % 5) == 0) hs_in = ~hs_in;
    if (($urandom % 20) == 0) vs_in = ~vs_in;
    rgb_in = 24'($urandom);
  endtask

  // mode 0 writes, 1 reads, 2 video, else everything
  task automatic run_phase(input int cycles, input int mode);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge clk_74a);
      drive_sources();
      case (mode)
        0: drive_write();
        1: drive_read();
        2: begin
          drive_video();
          // overscan flips now and then for the slot word
          bridge_addr    = 32'h0000_0200;
          bridge_wr      = ($urandom % 40) == 0;
          bridge_wr_data = $urandom;
        end
        default: begin
          drive_video();
          if (($urandom % 2) == 0) drive_write();
          else drive_read();
        end
      endcase
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("closing report: %0d checks, %0d errors", check_count, error_count);
    if (timed_out || error_count != 0) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // stimulus
  initial begin
    void'($urandom(SEED));
    bridge_addr       = 32'd0;
    bridge_wr         = 1'b0;
    bridge_wr_data    = 32'd0;
    bridge_rd         = 1'b0;
    cmd_rd_data       = 32'd0;
    save_rd_data      = 32'd0;
    savestate_rd_data = 32'd0;
    has_save          = 1'b0;
    h_blank           = 1'b0;
    v_blank           = 1'b0;
    hs_in             = 1'b0;
    vs_in             = 1'b0;
    rgb_in            = 24'd0;
    hold_reset();
    run_phase(WRITE_CYCLES, 0);
    run_phase(READ_CYCLES, 1);
    run_phase(VIDEO_CYCLES, 2);
    // reset in the middle of live video
    @(negedge clk_74a);
    hold_reset();
    run_phase(MIXED_CYCLES, 3);
    repeat (4) @(negedge clk_74a);
    finish_run(1'b0);
  end

  // run limit
  always @(posedge clk_74a) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      finish_run(1'b1);
    end
  end

endmodule
